// ==== list.f ====
+incdir+.
decode_pkg.sv
instr_decoder.sv
operand_select.sv
issue_ctrl.sv
decode_issue.sv
decode_issue_assertions.sv
decode_issue_tb.sv

// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - instr_decoder.sv
      - operand_select.sv
      - issue_ctrl.sv
      - decode_issue.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - decode_issue_assertions.sv
      - decode_issue_tb.sv

// ==== decode_issue_tb.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decode_issue_tb;

    typedef struct packed {
        logic [1:0]             stn;   // 0 none, 1 alu, 2 cmp
        logic                   ren;
        decode_pkg::alu_issue_t alu;
        decode_pkg::cmp_issue_t cmp;
        decode_pkg::rob_entry_t rob;
    } expect_t;

    localparam int N_INSTR = 38;
    localparam int LIMIT   = N_INSTR * 4 + 50;

    logic clk = 1'b0;
    logic reset_i = 1'b1;
    logic flush_i = 1'b0;
    logic queue_empty_i = 1'b1;
    logic rob_full_i = 1'b0;
    logic alu_full_i = 1'b0;
    logic cmp_full_i = 1'b0;
    decode_pkg::queue_entry_t queue_head_i = '0;
    decode_pkg::regfile_read_t regfile_i;
    decode_pkg::rob_tag_t rob_free_tag_i = 3'd1;
    decode_pkg::rob_fwd_t [`ROB_DEPTH-1:0] fwd = '0;
    logic queue_read_o;
    logic rename_we_o;
    logic rob_write_o;
    decode_pkg::reg_idx_t rs1_o;
    decode_pkg::reg_idx_t rs2_o;
    decode_pkg::reg_idx_t rename_rd_o;
    decode_pkg::rob_tag_t rename_tag_o;
    decode_pkg::rob_entry_t rob_entry_o;
    decode_pkg::alu_issue_t alu_o;
    decode_pkg::cmp_issue_t cmp_o;

    decode_pkg::word_t rf_val [32];
    decode_pkg::rob_tag_t rf_tag [32];
    decode_pkg::reg_idx_t ref_last_rd = '0;
    decode_pkg::rob_tag_t ref_last_tag = '0;
    expect_t exp_next;
    expect_t exp_cur;
    logic armed = 1'b0;
    logic checking = 1'b0;
    int seed = 32'hc144ee1f;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int test_err0 = 0;
    int cycles = 0;
    int br_funct3 [6] = '{0, 1, 4, 5, 6, 7};
    decode_pkg::word_t pc = 32'h0000_1000;

    decode_issue dut_i (.*, .rob_fwd_i(fwd));

    always #10 clk = ~clk;

    // register file model answers the read indices directly
    assign regfile_i.rs1_value = rf_val[rs1_o];
    assign regfile_i.rs1_tag   = rf_tag[rs1_o];
    assign regfile_i.rs2_value = rf_val[rs2_o];
    assign regfile_i.rs2_tag   = rf_tag[rs2_o];

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_val(string name, logic [159:0] got, logic [159:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    function automatic decode_pkg::operand_t resolve_operand(decode_pkg::reg_idx_t idx,
            decode_pkg::word_t val, decode_pkg::rob_tag_t tag,
            decode_pkg::reg_idx_t lrd, decode_pkg::rob_tag_t ltag);
        if (idx != 0 && idx == lrd)
            return {32'h0, 1'b0, ltag};
        if (tag != 0 && fwd[tag].ready)
            return {fwd[tag].value, 1'b1, 3'd0};
        return {val, tag == 0, tag};
    endfunction

    function automatic expect_t ref_model(decode_pkg::word_t ins, decode_pkg::word_t ipc,
            decode_pkg::regfile_read_t rf, decode_pkg::reg_idx_t lrd,
            decode_pkg::rob_tag_t ltag, decode_pkg::rob_tag_t free);
        expect_t e;
        logic [6:0] opc;
        logic [2:0] f3;
        decode_pkg::operand_t a;
        decode_pkg::operand_t b;
        decode_pkg::word_t i_imm;
        decode_pkg::word_t u_imm;
        e = '0;
        opc = ins[6:0];
        f3 = ins[14:12];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        u_imm = {ins[31:12], 12'h0};
        a = resolve_operand(ins[19:15], rf.rs1_value, rf.rs1_tag, lrd, ltag);
        b = resolve_operand(ins[24:20], rf.rs2_value, rf.rs2_tag, lrd, ltag);
        case (opc)
            `OPC_LUI, `OPC_AUIPC: begin
                e.stn = 1;
                a = {(opc == `OPC_AUIPC) ? ipc : 32'h0, 1'b1, 3'd0};
                b = {u_imm, 1'b1, 3'd0};
            end
            `OPC_IMM, `OPC_REG: begin
                e.stn = (f3 == 3'd2 || f3 == 3'd3) ? 2 : 1;
                if (opc == `OPC_IMM)
                    b = {i_imm, 1'b1, 3'd0};
                e.alu.op[2:0] = f3;
                e.alu.op[3] = ins[30] && (f3 == 3'd5 || (f3 == 3'd0 && opc == `OPC_REG));
            end
            `OPC_BR: begin
                e.stn = 2;
                e.cmp.br = 1'b1;
                e.cmp.b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: e.stn = 0;
        endcase
        if (opc != `OPC_BR && ins[11:7] == 0)
            e.stn = 0;   // rd zero is dropped
        e.ren = e.stn != 0 && opc != `OPC_BR;
        e.alu.valid = (e.stn == 1);
        e.alu.src1 = a;
        e.alu.src2 = b;
        e.alu.rob_tag = free;
        e.cmp.valid = (e.stn == 2);
        e.cmp.op = f3;
        e.cmp.src1 = a;
        e.cmp.src2 = b;
        e.cmp.pc = ipc;
        e.cmp.rob_tag = free;
        e.rob.pc = ipc;
        e.rob.opcode = opc;
        e.rob.rd = (opc == `OPC_BR) ? 5'd0 : ins[11:7];   // branches carry no rd
        return e;
    endfunction

    // kind 0 none, 1 alu full, 2 cmp full, 3 rob full, 4 no free tag, 5 queue empty
    task automatic issue(decode_pkg::word_t ins, int kind = 0);
        decode_pkg::rob_tag_t saved;
        decode_pkg::regfile_read_t rf_exp;
        saved = rob_free_tag_i;
        queue_head_i = {pc, ins};
        queue_empty_i = (kind == 5);
        alu_full_i = (kind == 1);
        cmp_full_i = (kind == 2);
        rob_full_i = (kind == 3);
        if (kind == 4) rob_free_tag_i = '0;
        if (kind != 0) begin
            repeat (3) begin
                @(negedge clk);
                check_val("queue_read_o", queue_read_o, 0);
                check_val("rename_we_o", rename_we_o, 0);
            end
            @(posedge clk);
            #1;
            {queue_empty_i, alu_full_i, cmp_full_i, rob_full_i} = '0;
            rob_free_tag_i = saved;
        end
        do @(negedge clk); while (!queue_read_o);
        rf_exp = {rf_val[ins[19:15]], rf_tag[ins[19:15]], rf_val[ins[24:20]], rf_tag[ins[24:20]]};
        exp_next = ref_model(ins, pc, rf_exp, ref_last_rd, ref_last_tag, rob_free_tag_i);
        check_val("rename_we_o", rename_we_o, exp_next.ren);
        if (exp_next.ren) begin
            check_val("rename_rd_o", rename_rd_o, ins[11:7]);
            check_val("rename_tag_o", rename_tag_o, rob_free_tag_i);
            ref_last_rd = ins[11:7];
            ref_last_tag = rob_free_tag_i;
        end
        @(posedge clk);
        #1;
        exp_cur = exp_next;
        armed = 1'b1;
        queue_empty_i = 1'b1;
        rob_free_tag_i = (rob_free_tag_i == 7) ? 3'd1 : rob_free_tag_i + 1;
        pc += 4;
    endtask

    always @(negedge clk) begin
        if (checking && armed) begin
            check_val("alu_o.valid", alu_o.valid, exp_cur.stn == 1);
            check_val("cmp_o.valid", cmp_o.valid, exp_cur.stn == 2);
            check_val("rob_write_o", rob_write_o, exp_cur.stn != 0);
            if (exp_cur.stn == 1) check_val("alu_o", alu_o, exp_cur.alu);
            if (exp_cur.stn == 2) check_val("cmp_o", cmp_o, exp_cur.cmp);
            if (exp_cur.stn != 0) check_val("rob_entry_o", rob_entry_o, exp_cur.rob);
            armed = 1'b0;
        end else if (checking) begin
            check_val("idle valids", {alu_o.valid, cmp_o.valid, rob_write_o}, 0);
        end
    end

    task automatic end_test(string name);
        tests++;
        if (errors != test_err0) failed_tests++;
        $display("test %-12s %s", name, (errors == test_err0) ? "ok" : "failed");
        test_err0 = errors;
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            rf_val[i] = (i == 0) ? 0 : $random(seed);
            rf_tag[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1 reset_i = 1'b0;
        checking = 1'b1;
        end_test("reset");

        for (int f = 0; f < 8; f++)
            issue({7'h00, 5'(f + 2), 5'(f + 3), 3'(f), 5'(f + 1), `OPC_REG});
        issue({7'h20, 5'd6, 5'd5, 3'd0, 5'd4, `OPC_REG});   // sub
        issue({7'h20, 5'd9, 5'd8, 3'd5, 5'd7, `OPC_REG});   // sra
        for (int f = 0; f < 8; f++)
            issue({(f == 5) ? 12'h405 : 12'($random(seed)), 5'(f + 9), 3'(f), 5'(f + 20),
                   `OPC_IMM});
        end_test("arith");

        issue({20'hABCDE, 5'd3, `OPC_LUI});
        issue({20'h12345, 5'd4, `OPC_AUIPC});
        foreach (br_funct3[k])
            issue({1'b1, 6'h15, 5'd2, 5'd1, 3'(br_funct3[k]), 4'h6, 1'b0, `OPC_BR});
        end_test("classes");

        rf_tag[10] = 3'd3;
        fwd[3] = {1'b1, 32'hFEED_0003};
        rf_tag[13] = 3'd4;
        issue({7'h00, 5'd12, 5'd10, 3'd0, 5'd11, `OPC_REG});
        issue({7'h00, 5'd0, 5'd13, 3'd0, 5'd14, `OPC_REG});
        issue({7'h00, 5'd14, 5'd14, 3'd4, 5'd15, `OPC_REG});   // depends on x14
        rf_tag[10] = '0;
        rf_tag[13] = '0;
        end_test("operands");

        issue({7'h00, 5'd2, 5'd3, 3'd0, 5'd16, `OPC_REG}, 1);
        issue({1'b0, 6'h01, 5'd2, 5'd3, 3'd0, 4'h2, 1'b0, `OPC_BR}, 2);
        issue({12'h011, 5'd4, 3'd0, 5'd17, `OPC_IMM}, 3);
        issue({12'h012, 5'd4, 3'd6, 5'd18, `OPC_IMM}, 4);
        issue({12'h013, 5'd4, 3'd7, 5'd19, `OPC_IMM}, 5);
        end_test("backpress");

        issue({12'h055, 5'd1, 3'd0, 5'd0, `OPC_IMM});
        issue({12'h055, 5'd1, 3'd0, 5'd9, 7'b0001011});
        end_test("drop");

        issue({12'h005, 5'd0, 3'd0, 5'd20, `OPC_IMM});
        queue_head_i = {pc, 7'h00, 5'd20, 5'd20, 3'd0, 5'd21, `OPC_REG};
        queue_empty_i = 1'b0;
        flush_i = 1'b1;
        @(negedge clk);
        check_val("queue_read_o", queue_read_o, 0);
        @(posedge clk);
        #1 flush_i = 1'b0;
        ref_last_rd = '0;
        ref_last_tag = '0;
        issue({7'h00, 5'd20, 5'd20, 3'd0, 5'd21, `OPC_REG});
        end_test("flush");

        repeat (2) @(posedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== decode_issue_assertions.sv ====
`timescale 1ns/100ps

module decode_issue_assertions (
    input logic clk,
    input logic reset_i,
    input logic queue_read_o,
    input logic rename_we_o,
    input logic rob_write_o,
    input logic alu_valid_i,
    input logic cmp_valid_i
);

    one_station: assert property (@(posedge clk) disable iff (reset_i)
        !(alu_valid_i && cmp_valid_i))
        else $error("alu and cmp dispatch together");

    // a rob write is always the echo of a pop
    rob_after_pop: assert property (@(posedge clk) disable iff (reset_i)
        rob_write_o |-> $past(queue_read_o))
        else $error("rob write without a pop");

    dispatch_has_rob: assert property (@(posedge clk) disable iff (reset_i)
        (alu_valid_i || cmp_valid_i) |-> rob_write_o)
        else $error("dispatch without rob write");

    rename_needs_pop: assert property (@(posedge clk) disable iff (reset_i)
        rename_we_o |-> queue_read_o)
        else $error("rename without a pop");

endmodule

bind decode_issue decode_issue_assertions assert_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .queue_read_o (queue_read_o),
    .rename_we_o  (rename_we_o),
    .rob_write_o  (rob_write_o),
    .alu_valid_i  (alu_o.valid),
    .cmp_valid_i  (cmp_o.valid)
);

// ==== decode_issue.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module decode_issue (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 flush_i,
    input  decode_pkg::queue_entry_t             queue_head_i,
    input  logic                                 queue_empty_i,
    input  decode_pkg::regfile_read_t            regfile_i,
    input  decode_pkg::rob_tag_t                 rob_free_tag_i,
    input  logic                                 rob_full_i,
    input  decode_pkg::rob_fwd_t [`ROB_DEPTH-1:0] rob_fwd_i,
    input  logic                                 alu_full_i,
    input  logic                                 cmp_full_i,
    output logic                                 queue_read_o,
    output decode_pkg::reg_idx_t                 rs1_o,
    output decode_pkg::reg_idx_t                 rs2_o,
    output logic                                 rename_we_o,
    output decode_pkg::reg_idx_t                 rename_rd_o,
    output decode_pkg::rob_tag_t                 rename_tag_o,
    output logic                                 rob_write_o,
    output decode_pkg::rob_entry_t               rob_entry_o,
    output decode_pkg::alu_issue_t               alu_o,
    output decode_pkg::cmp_issue_t               cmp_o
);

    decode_pkg::decoded_t dec;
    decode_pkg::operand_t src1;
    decode_pkg::operand_t src2;
    decode_pkg::reg_idx_t last_rd;
    decode_pkg::rob_tag_t last_tag;

    assign rs1_o = dec.rs1;   // regfile read indices
    assign rs2_o = dec.rs2;

    instr_decoder decoder_i (
        .instr_i (queue_head_i.instr),
        .pc_i    (queue_head_i.pc),
        .dec_o   (dec)
    );

    operand_select src1_sel_i (
        .src_idx_i  (dec.rs1),
        .rf_value_i (regfile_i.rs1_value),
        .rf_tag_i   (regfile_i.rs1_tag),
        .last_rd_i  (last_rd),
        .last_tag_i (last_tag),
        .rob_fwd_i  (rob_fwd_i),
        .operand_o  (src1)
    );

    operand_select src2_sel_i (
        .src_idx_i  (dec.rs2),
        .rf_value_i (regfile_i.rs2_value),
        .rf_tag_i   (regfile_i.rs2_tag),
        .last_rd_i  (last_rd),
        .last_tag_i (last_tag),
        .rob_fwd_i  (rob_fwd_i),
        .operand_o  (src2)
    );

    issue_ctrl issue_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .dec_i          (dec),
        .pc_i           (queue_head_i.pc),
        .src1_i         (src1),
        .src2_i         (src2),
        .queue_empty_i  (queue_empty_i),
        .rob_full_i     (rob_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .queue_read_o   (queue_read_o),
        .rename_we_o    (rename_we_o),
        .rename_rd_o    (rename_rd_o),
        .rename_tag_o   (rename_tag_o),
        .last_rd_o      (last_rd),
        .last_tag_o     (last_tag),
        .rob_write_o    (rob_write_o),
        .rob_entry_o    (rob_entry_o),
        .alu_o          (alu_o),
        .cmp_o          (cmp_o)
    );

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module issue_ctrl (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  decode_pkg::decoded_t   dec_i,
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::operand_t   src1_i,
    input  decode_pkg::operand_t   src2_i,
    input  logic                   queue_empty_i,
    input  logic                   rob_full_i,
    input  decode_pkg::rob_tag_t   rob_free_tag_i,
    input  logic                   alu_full_i,
    input  logic                   cmp_full_i,
    output logic                   queue_read_o,
    output logic                   rename_we_o,
    output decode_pkg::reg_idx_t   rename_rd_o,
    output decode_pkg::rob_tag_t   rename_tag_o,
    output decode_pkg::reg_idx_t   last_rd_o,
    output decode_pkg::rob_tag_t   last_tag_o,
    output logic                   rob_write_o,
    output decode_pkg::rob_entry_t rob_entry_o,
    output decode_pkg::alu_issue_t alu_o,
    output decode_pkg::cmp_issue_t cmp_o
);

    logic                   to_alu;
    logic                   to_cmp;
    logic                   station_busy;
    logic                   accept;
    logic                   dispatch;
    decode_pkg::operand_t   op1;
    decode_pkg::operand_t   op2;

    assign to_alu = (dec_i.station == `STN_ALU);
    assign to_cmp = (dec_i.station == `STN_CMP);

    assign station_busy = (to_alu && alu_full_i) || (to_cmp && cmp_full_i);

    assign accept = !queue_empty_i && !flush_i && !rob_full_i
                    && (rob_free_tag_i != '0) && !station_busy;

    // rd zero or unknown opcode is popped and dropped
    assign dispatch = accept && (to_alu || to_cmp)
                      && (!dec_i.writes_rd || dec_i.rd != '0);

    assign queue_read_o = accept;
    assign rename_we_o  = accept && dec_i.writes_rd && (dec_i.rd != '0);
    assign rename_rd_o  = dec_i.rd;
    assign rename_tag_o = rob_free_tag_i;

    // fixed base or immediate replaces unused sources
    always_comb begin
        op1 = src1_i;
        op2 = src2_i;
        if (!dec_i.use_rs1) begin
            op1.value = dec_i.base;
            op1.ready = 1'b1;
            op1.tag   = '0;
        end
        if (!dec_i.use_rs2) begin
            op2.value = dec_i.imm;
            op2.ready = 1'b1;
            op2.tag   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            last_rd_o  <= '0;
            last_tag_o <= '0;
        end else if (rename_we_o) begin
            last_rd_o  <= dec_i.rd;
            last_tag_o <= rob_free_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rob_write_o <= 1'b0;
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
        end else begin
            rob_write_o <= dispatch;   // low under flush since accept is low
            alu_o.valid <= dispatch && to_alu;
            cmp_o.valid <= dispatch && to_cmp;
        end
        if (dispatch) begin
            rob_entry_o.pc     <= pc_i;
            rob_entry_o.opcode <= dec_i.opcode;
            rob_entry_o.rd     <= dec_i.writes_rd ? dec_i.rd : '0;
        end
        if (dispatch && to_alu) begin
            alu_o.op      <= dec_i.alu_op;
            alu_o.src1    <= op1;
            alu_o.src2    <= op2;
            alu_o.rob_tag <= rob_free_tag_i;
        end
        if (dispatch && to_cmp) begin
            cmp_o.br      <= (dec_i.opcode == `OPC_BR);
            cmp_o.op      <= dec_i.funct3;
            cmp_o.src1    <= op1;
            cmp_o.src2    <= op2;
            cmp_o.pc      <= pc_i;
            cmp_o.b_imm   <= dec_i.b_imm;
            cmp_o.rob_tag <= rob_free_tag_i;
        end
    end

endmodule

// ==== operand_select.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module operand_select (
    input  decode_pkg::reg_idx_t                 src_idx_i,
    input  decode_pkg::word_t                    rf_value_i,
    input  decode_pkg::rob_tag_t                 rf_tag_i,
    input  decode_pkg::reg_idx_t                 last_rd_i,
    input  decode_pkg::rob_tag_t                 last_tag_i,
    input  decode_pkg::rob_fwd_t [`ROB_DEPTH-1:0] rob_fwd_i,
    output decode_pkg::operand_t                 operand_o
);

    decode_pkg::rob_fwd_t fwd;

    assign fwd = rob_fwd_i[rf_tag_i];

    always_comb begin
        if (src_idx_i != '0 && src_idx_i == last_rd_i) begin
            // producer renamed last cycle, regfile not updated yet
            operand_o.value = '0;
            operand_o.ready = 1'b0;
            operand_o.tag   = last_tag_i;
        end else if (rf_tag_i != '0 && fwd.ready) begin
            operand_o.value = fwd.value;   // rob has the result
            operand_o.ready = 1'b1;
            operand_o.tag   = '0;
        end else begin
            operand_o.value = rf_value_i;
            operand_o.ready = (rf_tag_i == '0);
            operand_o.tag   = rf_tag_i;
        end
    end

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps
`include "decode_defines.svh"

module instr_decoder (
    input  decode_pkg::word_t    instr_i,
    input  decode_pkg::word_t    pc_i,
    output decode_pkg::decoded_t dec_o
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;
    decode_pkg::word_t   i_imm;
    decode_pkg::word_t   u_imm;
    decode_pkg::word_t   b_imm;
    logic                alt_bit;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign u_imm = {instr_i[31:12], 12'h000};
    assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // bit 30 selects sub/sra, but in op-imm only srai has it
    always_comb begin
        alt_bit = 1'b0;
        if (opcode == `OPC_REG && (funct3 == `F3_ADD || funct3 == `F3_SR)) begin
            alt_bit = instr_i[30];
        end else if (opcode == `OPC_IMM && funct3 == `F3_SR) begin
            alt_bit = instr_i[30];
        end
    end

    always_comb begin
        dec_o.rs1       = instr_i[19:15];
        dec_o.rs2       = instr_i[24:20];
        dec_o.rd        = instr_i[11:7];
        dec_o.opcode    = opcode;
        dec_o.funct3    = funct3;
        dec_o.alu_op    = {alt_bit, funct3};
        dec_o.imm       = i_imm;
        dec_o.b_imm     = '0;
        dec_o.base      = '0;
        dec_o.use_rs1   = 1'b0;
        dec_o.use_rs2   = 1'b0;
        dec_o.station   = `STN_NONE;
        dec_o.writes_rd = 1'b0;

        case (opcode)
            `OPC_LUI, `OPC_AUIPC: begin
                dec_o.imm       = u_imm;
                dec_o.base      = (opcode == `OPC_AUIPC) ? pc_i : '0;
                dec_o.alu_op    = {1'b0, `F3_ADD};
                dec_o.station   = `STN_ALU;
                dec_o.writes_rd = 1'b1;
            end
            `OPC_IMM, `OPC_REG: begin
                dec_o.use_rs1   = 1'b1;
                dec_o.use_rs2   = (opcode == `OPC_REG);
                dec_o.writes_rd = 1'b1;
                if (funct3 == `F3_SLT || funct3 == `F3_SLTU)
                    dec_o.station = `STN_CMP;   // set-less-than goes to compare
                else
                    dec_o.station = `STN_ALU;
            end
            `OPC_BR: begin
                dec_o.b_imm   = b_imm;
                dec_o.use_rs1 = 1'b1;
                dec_o.use_rs2 = 1'b1;
                dec_o.station = `STN_CMP;
            end
            default: ;   // unknown, consumed without dispatch
        endcase
    end

endmodule

// ==== decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [3:0]            alu_op_t;   // {alt bit, funct3}
    typedef logic [1:0]            station_t;

    typedef struct packed {
        word_t    value;
        logic     ready;
        rob_tag_t tag;
    } operand_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } queue_entry_t;

    typedef struct packed {
        word_t    rs1_value;
        rob_tag_t rs1_tag;
        word_t    rs2_value;
        rob_tag_t rs2_tag;
    } regfile_read_t;

    typedef struct packed {
        logic  ready;
        word_t value;
    } rob_fwd_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  op;
        operand_t src1;
        operand_t src2;
        rob_tag_t rob_tag;
    } alu_issue_t;

    typedef struct packed {
        logic     valid;
        logic     br;
        funct3_t  op;
        operand_t src1;
        operand_t src2;
        word_t    pc;
        word_t    b_imm;
        rob_tag_t rob_tag;
    } cmp_issue_t;

    typedef struct packed {
        word_t    pc;
        opcode_t  opcode;
        reg_idx_t rd;
    } rob_entry_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        opcode_t  opcode;
        funct3_t  funct3;
        alu_op_t  alu_op;
        word_t    imm;       // I or U immediate
        word_t    b_imm;     // zero unless branch
        word_t    base;      // fixed src1 when rs1 unused
        logic     use_rs1;
        logic     use_rs2;
        station_t station;
        logic     writes_rd;
    } decoded_t;

endpackage

// ==== decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define XLEN      32
`define REG_IDX_W 5
`define ROB_TAG_W 3   // tag 0 means no producer
`define ROB_DEPTH 8

// major opcodes
`define OPC_LUI   7'b0110111
`define OPC_AUIPC 7'b0010111
`define OPC_BR    7'b1100011
`define OPC_IMM   7'b0010011
`define OPC_REG   7'b0110011

// funct3 values used in classification
`define F3_ADD  3'b000
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_SR   3'b101

// target station codes
`define STN_NONE 2'd0
`define STN_ALU  2'd1
`define STN_CMP  2'd2

`endif
